// ==== hdl/rv_pkg.sv ====
package rv_pkg;

    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int DMEM_WORDS  = 64;
    localparam int DMEM_ADDR_W = $clog2(DMEM_WORDS);

    // ADDI x0, x0, 0
    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

    // Forwarding mux selects
    localparam logic [1:0] FWD_NONE = 2'b00;
    localparam logic [1:0] FWD_EX   = 2'b01;
    localparam logic [1:0] FWD_WB   = 2'b10;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLT    = 4'd5,
        ALU_SLL    = 4'd6,
        ALU_SRL    = 4'd7,
        ALU_PASS_B = 4'd8
    } alu_op_e;

    typedef struct packed {
        logic mem_write;
        logic mem2reg;
        logic reg_write;
        logic alu_src;
    } ctrl_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } if_id_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
        logic [XLEN-1:0]       imm;
        alu_op_e               alu_op;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        ctrl_t                 ctrl;
    } id_ex_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       alu_result;
        logic [XLEN-1:0]       write_data;
        logic [REG_ADDR_W-1:0] rd;
        ctrl_t                 ctrl;
    } ex_mem_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       alu_result;
        logic [XLEN-1:0]       mem_data;
        logic [REG_ADDR_W-1:0] rd;
        ctrl_t                 ctrl;
    } mem_wb_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic                  we;
        logic [XLEN-1:0]       data;
    } retire_t;

endpackage

// ==== hdl/pipe_reg.sv ====
module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     i_rst_n,
    input  logic     i_hold,
    input  logic     i_bubble,
    input  payload_t i_d,
    output payload_t o_q
);

    // All-zero payload is an invalid slot with every control bit low
    always_ff @(posedge clk)
    begin
        if (!i_rst_n || i_bubble)
        begin
            o_q <= '0;
        end
        else if (!i_hold)
        begin
            o_q <= i_d;
        end
    end

endmodule

// ==== hdl/reg_file.sv ====
module reg_file (
    input  logic                          clk,
    input  logic                          i_rst_n,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rs1,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rs2,
    input  logic                          i_we,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rd,
    input  logic [rv_pkg::XLEN-1:0]       i_wdata,
    output logic [rv_pkg::XLEN-1:0]       o_rs1_data,
    output logic [rv_pkg::XLEN-1:0]       o_rs2_data
);

    // x0 has no storage
    logic [rv_pkg::XLEN-1:0] regs [1:31];

    always_ff @(posedge clk)
    begin
        if (!i_rst_n)
        begin
            for (int i = 1; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (i_we && (i_rd != '0))
        begin
            regs[i_rd] <= i_wdata;
        end
    end

    function automatic logic [rv_pkg::XLEN-1:0] read_port(
        input logic [rv_pkg::REG_ADDR_W-1:0] addr
    );
        if (addr == '0)
        begin
            return '0;
        end
        // Same-cycle write is visible to the reader
        if (i_we && (addr == i_rd))
        begin
            return i_wdata;
        end
        return regs[addr];
    endfunction

    assign o_rs1_data = read_port(i_rs1);
    assign o_rs2_data = read_port(i_rs2);

endmodule

// ==== hdl/decode_stage.sv ====
module decode_stage (
    input  rv_pkg::if_id_t                i_if_id,
    input  logic [rv_pkg::XLEN-1:0]       i_rs1_data,
    input  logic [rv_pkg::XLEN-1:0]       i_rs2_data,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_rs1,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_rs2,
    output rv_pkg::id_ex_t                o_id_ex
);

    logic [rv_pkg::XLEN-1:0] instr;
    logic [6:0]              opcode;
    logic [2:0]              funct3;
    logic [6:0]              funct7;

    assign instr  = i_if_id.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign o_rs1  = instr[19:15];
    assign o_rs2  = instr[24:20];

    always_comb
    begin
        o_id_ex          = '0;
        o_id_ex.valid    = i_if_id.valid;
        o_id_ex.rs1_data = i_rs1_data;
        o_id_ex.rs2_data = i_rs2_data;
        o_id_ex.rs1      = o_rs1;
        o_id_ex.rs2      = o_rs2;
        o_id_ex.rd       = instr[11:7];
        o_id_ex.alu_op   = rv_pkg::ALU_ADD;
        // I-type by default
        o_id_ex.imm      = {{20{instr[31]}}, instr[31:20]};

        case (opcode)
            rv_pkg::OPC_OP:
            begin
                o_id_ex.ctrl.reg_write = (funct7 == 7'h00)
                                      || (funct7 == 7'h20 && funct3 == 3'b000);
                case (funct3)
                    3'b000: o_id_ex.alu_op = funct7[5] ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                    3'b001: o_id_ex.alu_op = rv_pkg::ALU_SLL;
                    3'b010: o_id_ex.alu_op = rv_pkg::ALU_SLT;
                    3'b100: o_id_ex.alu_op = rv_pkg::ALU_XOR;
                    3'b101: o_id_ex.alu_op = rv_pkg::ALU_SRL;
                    3'b110: o_id_ex.alu_op = rv_pkg::ALU_OR;
                    3'b111: o_id_ex.alu_op = rv_pkg::ALU_AND;
                    default: o_id_ex.ctrl.reg_write = 1'b0;
                endcase
            end
            rv_pkg::OPC_OP_IMM:
            begin
                o_id_ex.ctrl.alu_src   = 1'b1;
                o_id_ex.ctrl.reg_write = 1'b1;
                case (funct3)
                    3'b000: o_id_ex.alu_op = rv_pkg::ALU_ADD;
                    3'b010: o_id_ex.alu_op = rv_pkg::ALU_SLT;
                    3'b100: o_id_ex.alu_op = rv_pkg::ALU_XOR;
                    3'b110: o_id_ex.alu_op = rv_pkg::ALU_OR;
                    3'b111: o_id_ex.alu_op = rv_pkg::ALU_AND;
                    // Shift immediates and SLTIU are not supported
                    default: o_id_ex.ctrl = '0;
                endcase
            end
            rv_pkg::OPC_LUI:
            begin
                o_id_ex.imm            = {instr[31:12], 12'b0};
                o_id_ex.alu_op         = rv_pkg::ALU_PASS_B;
                o_id_ex.ctrl.alu_src   = 1'b1;
                o_id_ex.ctrl.reg_write = 1'b1;
            end
            rv_pkg::OPC_LOAD:
            begin
                o_id_ex.ctrl.alu_src   = (funct3 == 3'b010);
                o_id_ex.ctrl.mem2reg   = (funct3 == 3'b010);
                o_id_ex.ctrl.reg_write = (funct3 == 3'b010);
            end
            rv_pkg::OPC_STORE:
            begin
                o_id_ex.imm            = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                o_id_ex.ctrl.alu_src   = (funct3 == 3'b010);
                o_id_ex.ctrl.mem_write = (funct3 == 3'b010);
            end
            default:
            begin
                o_id_ex.ctrl = '0;
            end
        endcase

        // Writes to x0 are dropped here so later stages never see them
        if (o_id_ex.rd == '0)
        begin
            o_id_ex.ctrl.reg_write = 1'b0;
        end
    end

endmodule

// ==== hdl/hazard_unit.sv ====
module hazard_unit (
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_if_id_rs1,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_if_id_rs2,
    input  rv_pkg::id_ex_t                i_id_ex,
    input  rv_pkg::ex_mem_t               i_ex_mem,
    input  rv_pkg::mem_wb_t               i_mem_wb,
    output logic [1:0]                    o_fwd_a,
    output logic [1:0]                    o_fwd_b,
    output logic                          o_stall
);

    logic ex_writes;
    logic wb_writes;
    logic id_ex_load;

    assign ex_writes = i_ex_mem.valid && i_ex_mem.ctrl.reg_write && (i_ex_mem.rd != '0);
    assign wb_writes = i_mem_wb.valid && i_mem_wb.ctrl.reg_write && (i_mem_wb.rd != '0);

    // EX/MEM holds the younger result and takes priority
    function automatic logic [1:0] fwd_sel(input logic [rv_pkg::REG_ADDR_W-1:0] rs);
        if (ex_writes && (i_ex_mem.rd == rs))
        begin
            return rv_pkg::FWD_EX;
        end
        if (wb_writes && (i_mem_wb.rd == rs))
        begin
            return rv_pkg::FWD_WB;
        end
        return rv_pkg::FWD_NONE;
    endfunction

    assign o_fwd_a = fwd_sel(i_id_ex.rs1);
    assign o_fwd_b = fwd_sel(i_id_ex.rs2);

    // Load result is not ready until MEM/WB, so the consumer waits one cycle
    assign id_ex_load = i_id_ex.valid && i_id_ex.ctrl.mem2reg && (i_id_ex.rd != '0);
    assign o_stall    = id_ex_load
                     && ((i_id_ex.rd == i_if_id_rs1) || (i_id_ex.rd == i_if_id_rs2));

endmodule

// ==== hdl/execute_stage.sv ====
module execute_stage (
    input  rv_pkg::id_ex_t          i_id_ex,
    input  logic [1:0]              i_fwd_a,
    input  logic [1:0]              i_fwd_b,
    input  logic [rv_pkg::XLEN-1:0] i_ex_fwd_data,
    input  logic [rv_pkg::XLEN-1:0] i_wb_fwd_data,
    output rv_pkg::ex_mem_t         o_ex_mem
);

    logic [rv_pkg::XLEN-1:0] op_a;
    logic [rv_pkg::XLEN-1:0] rs2_val;
    logic [rv_pkg::XLEN-1:0] op_b;
    logic [rv_pkg::XLEN-1:0] result;

    function automatic logic [rv_pkg::XLEN-1:0] fwd_mux(
        input logic [1:0]              sel,
        input logic [rv_pkg::XLEN-1:0] reg_val
    );
        case (sel)
            rv_pkg::FWD_EX: return i_ex_fwd_data;
            rv_pkg::FWD_WB: return i_wb_fwd_data;
            default:        return reg_val;
        endcase
    endfunction

    assign op_a    = fwd_mux(i_fwd_a, i_id_ex.rs1_data);
    assign rs2_val = fwd_mux(i_fwd_b, i_id_ex.rs2_data);
    assign op_b    = i_id_ex.ctrl.alu_src ? i_id_ex.imm : rs2_val;

    always_comb
    begin
        case (i_id_ex.alu_op)
            rv_pkg::ALU_ADD:    result = op_a + op_b;
            rv_pkg::ALU_SUB:    result = op_a - op_b;
            rv_pkg::ALU_AND:    result = op_a & op_b;
            rv_pkg::ALU_OR:     result = op_a | op_b;
            rv_pkg::ALU_XOR:    result = op_a ^ op_b;
            rv_pkg::ALU_SLT:    result = {{(rv_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            rv_pkg::ALU_SLL:    result = op_a << op_b[4:0];
            rv_pkg::ALU_SRL:    result = op_a >> op_b[4:0];
            rv_pkg::ALU_PASS_B: result = op_b;
            default:            result = '0;
        endcase
    end

    always_comb
    begin
        o_ex_mem.valid      = i_id_ex.valid;
        o_ex_mem.alu_result = result;
        // Store data is the forwarded rs2, not the immediate
        o_ex_mem.write_data = rs2_val;
        o_ex_mem.rd         = i_id_ex.rd;
        o_ex_mem.ctrl       = i_id_ex.ctrl;
    end

endmodule

// ==== hdl/data_mem.sv ====
module data_mem (
    input  logic                    clk,
    input  logic                    i_we,
    input  logic [rv_pkg::XLEN-1:0] i_addr,
    input  logic [rv_pkg::XLEN-1:0] i_wdata,
    output logic [rv_pkg::XLEN-1:0] o_rdata
);

    logic [rv_pkg::XLEN-1:0]        mem [rv_pkg::DMEM_WORDS];
    logic [rv_pkg::DMEM_ADDR_W-1:0] word_idx;

    // Byte offset dropped, upper address bits wrap
    assign word_idx = i_addr[rv_pkg::DMEM_ADDR_W+1:2];

    always_ff @(posedge clk)
    begin
        if (i_we)
        begin
            mem[word_idx] <= i_wdata;
        end
    end

    assign o_rdata = mem[word_idx];

endmodule

// ==== hdl/rv_core_top.sv ====
module rv_core_top (
    input  logic                    clk,
    input  logic                    i_rst_n,
    output logic [rv_pkg::XLEN-1:0] o_imem_addr,
    input  logic [rv_pkg::XLEN-1:0] i_imem_instr,
    output rv_pkg::retire_t         o_retire
);

    logic [rv_pkg::XLEN-1:0]       pc_q;
    logic                          stall;
    logic [1:0]                    fwd_a;
    logic [1:0]                    fwd_b;
    logic [rv_pkg::REG_ADDR_W-1:0] dec_rs1;
    logic [rv_pkg::REG_ADDR_W-1:0] dec_rs2;
    logic [rv_pkg::XLEN-1:0]       rs1_data;
    logic [rv_pkg::XLEN-1:0]       rs2_data;
    logic [rv_pkg::XLEN-1:0]       dmem_rdata;
    logic                          dmem_we;
    logic                          rf_we;
    logic [rv_pkg::XLEN-1:0]       wb_data;

    rv_pkg::if_id_t  if_id_d,  if_id;
    rv_pkg::id_ex_t  id_ex_d,  id_ex;
    rv_pkg::ex_mem_t ex_mem_d, ex_mem;
    rv_pkg::mem_wb_t mem_wb_d, mem_wb;

    always_ff @(posedge clk)
    begin
        if (!i_rst_n)
        begin
            pc_q <= '0;
        end
        else if (!stall)
        begin
            pc_q <= pc_q + 32'd4;
        end
    end

    assign o_imem_addr = pc_q;

    always_comb
    begin
        if_id_d.valid = 1'b1;
        if_id_d.pc    = pc_q;
        if_id_d.instr = i_imem_instr;
    end

    pipe_reg #(.payload_t(rv_pkg::if_id_t)) if_id_q (
        .clk(clk), .i_rst_n(i_rst_n), .i_hold(stall), .i_bubble(1'b0),
        .i_d(if_id_d), .o_q(if_id)
    );

    decode_stage u_decode (
        .i_if_id(if_id), .i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
        .o_rs1(dec_rs1), .o_rs2(dec_rs2), .o_id_ex(id_ex_d)
    );

    reg_file u_reg_file (
        .clk(clk), .i_rst_n(i_rst_n), .i_rs1(dec_rs1), .i_rs2(dec_rs2),
        .i_we(rf_we), .i_rd(mem_wb.rd), .i_wdata(wb_data),
        .o_rs1_data(rs1_data), .o_rs2_data(rs2_data)
    );

    hazard_unit u_hazard (
        .i_if_id_rs1(dec_rs1), .i_if_id_rs2(dec_rs2), .i_id_ex(id_ex),
        .i_ex_mem(ex_mem), .i_mem_wb(mem_wb),
        .o_fwd_a(fwd_a), .o_fwd_b(fwd_b), .o_stall(stall)
    );

    // Load-use stall turns the ID/EX slot into a bubble
    pipe_reg #(.payload_t(rv_pkg::id_ex_t)) id_ex_q (
        .clk(clk), .i_rst_n(i_rst_n), .i_hold(1'b0), .i_bubble(stall),
        .i_d(id_ex_d), .o_q(id_ex)
    );

    execute_stage u_execute (
        .i_id_ex(id_ex), .i_fwd_a(fwd_a), .i_fwd_b(fwd_b),
        .i_ex_fwd_data(ex_mem.alu_result), .i_wb_fwd_data(wb_data),
        .o_ex_mem(ex_mem_d)
    );

    pipe_reg #(.payload_t(rv_pkg::ex_mem_t)) ex_mem_q (
        .clk(clk), .i_rst_n(i_rst_n), .i_hold(1'b0), .i_bubble(1'b0),
        .i_d(ex_mem_d), .o_q(ex_mem)
    );

    assign dmem_we = ex_mem.valid && ex_mem.ctrl.mem_write;

    data_mem u_data_mem (
        .clk(clk), .i_we(dmem_we), .i_addr(ex_mem.alu_result),
        .i_wdata(ex_mem.write_data), .o_rdata(dmem_rdata)
    );

    always_comb
    begin
        mem_wb_d.valid      = ex_mem.valid;
        mem_wb_d.alu_result = ex_mem.alu_result;
        mem_wb_d.mem_data   = dmem_rdata;
        mem_wb_d.rd         = ex_mem.rd;
        mem_wb_d.ctrl       = ex_mem.ctrl;
    end

    pipe_reg #(.payload_t(rv_pkg::mem_wb_t)) mem_wb_q (
        .clk(clk), .i_rst_n(i_rst_n), .i_hold(1'b0), .i_bubble(1'b0),
        .i_d(mem_wb_d), .o_q(mem_wb)
    );

    // Writeback
    assign wb_data = mem_wb.ctrl.mem2reg ? mem_wb.mem_data : mem_wb.alu_result;
    assign rf_we   = mem_wb.valid && mem_wb.ctrl.reg_write;

    always_comb
    begin
        o_retire.valid = mem_wb.valid;
        o_retire.rd    = mem_wb.rd;
        o_retire.we    = rf_we;
        o_retire.data  = wb_data;
    end

endmodule

// ==== tb/rv_core_properties.sv ====
module rv_core_properties (
    input logic                    clk,
    input logic                    i_rst_n,
    input rv_pkg::retire_t         i_retire,
    input logic [rv_pkg::XLEN-1:0] i_imem_addr,
    input logic                    i_stall,
    input logic                    i_ex_mem_write,
    input logic                    i_ex_mem_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    int assert_errors = 0;

    // First instruction needs four cycles to reach writeback
    a_reset_quiet: assert property (@(posedge clk) $rose(i_rst_n) |-> !i_retire.valid [*4])
        else
        begin
            $error("retire valid before the pipeline could fill");
            assert_errors++;
        end

    a_x0_no_write: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_retire.valid && (i_retire.rd == '0)) |-> !i_retire.we)
        else
        begin
            $error("retire to x0 with write enable high");
            assert_errors++;
        end

    // Bubbles clear the store control together with valid
    a_store_valid: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_ex_mem_write |-> i_ex_mem_valid)
        else
        begin
            $error("store control set in an invalid EX/MEM slot");
            assert_errors++;
        end

    // PC holds for the load-use stall
    a_stall_pc: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_stall |=> $stable(i_imem_addr))
        else
        begin
            $error("fetch address moved during a stall");
            assert_errors++;
        end

endmodule

bind rv_core_top rv_core_properties u_props (
    .clk(clk),
    .i_rst_n(i_rst_n),
    .i_retire(o_retire),
    .i_imem_addr(o_imem_addr),
    .i_stall(stall),
    .i_ex_mem_write(ex_mem.ctrl.mem_write),
    .i_ex_mem_valid(ex_mem.valid)
);

// ==== tb/rv_core_tb.sv ====
module rv_core_tb;

    timeunit 1ns;
    timeprecision 1ps;

    logic                    clk;
    logic                    i_rst_n;
    logic [rv_pkg::XLEN-1:0] o_imem_addr;
    logic [rv_pkg::XLEN-1:0] i_imem_instr;
    rv_pkg::retire_t         o_retire;

    // Program words and the retire record each one must produce
    logic [rv_pkg::XLEN-1:0] prog_instr [$];
    rv_pkg::retire_t         prog_exp [$];

    int                      n_retired;
    int                      retire_errors;
    int                      fetch_errors;
    logic                    checking;
    logic [rv_pkg::XLEN-1:0] prev_pc;

    rv_core_top dut (
        .clk(clk), .i_rst_n(i_rst_n), .o_imem_addr(o_imem_addr),
        .i_imem_instr(i_imem_instr), .o_retire(o_retire)
    );

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_lw(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [4:0] rd);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] enc_sw(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    task automatic add_step(input logic [31:0] instr, input logic we, input logic [4:0] rd,
                            input logic [31:0] data);
        rv_pkg::retire_t exp;
        exp.valid = 1'b1;
        exp.rd    = rd;
        exp.we    = we;
        exp.data  = data;
        prog_instr.push_back(instr);
        prog_exp.push_back(exp);
    endtask

    task automatic load_program();
        // ALU ops with operands from EX/MEM, MEM/WB and the register bypass
        add_step(enc_i(12'd5, 0, 3'b000, 1), 1'b1, 1, 32'h0000_0005);
        add_step(enc_i(12'hFFD, 0, 3'b000, 2), 1'b1, 2, 32'hFFFF_FFFD);
        add_step(enc_r(7'h00, 2, 1, 3'b000, 3), 1'b1, 3, 32'h0000_0002);
        add_step(enc_r(7'h20, 3, 1, 3'b000, 4), 1'b1, 4, 32'h0000_0003);
        add_step(enc_r(7'h00, 3, 4, 3'b100, 5), 1'b1, 5, 32'h0000_0001);
        add_step(enc_r(7'h00, 5, 2, 3'b010, 6), 1'b1, 6, 32'h0000_0001);
        add_step(enc_r(7'h00, 4, 5, 3'b001, 7), 1'b1, 7, 32'h0000_0008);
        add_step(enc_r(7'h00, 7, 2, 3'b101, 8), 1'b1, 8, 32'h00FF_FFFF);
        add_step(enc_r(7'h00, 1, 7, 3'b110, 9), 1'b1, 9, 32'h0000_000D);
        add_step(enc_i(12'h0F0, 2, 3'b111, 10), 1'b1, 10, 32'h0000_00F0);
        add_step(enc_i(12'h00F, 10, 3'b110, 11), 1'b1, 11, 32'h0000_00FF);
        add_step(enc_i(12'hFFF, 11, 3'b100, 12), 1'b1, 12, 32'hFFFF_FF00);
        // -256 < -300 is false
        add_step(enc_i(12'hED4, 12, 3'b010, 13), 1'b1, 13, 32'h0000_0000);
        add_step({20'h12345, 5'd14, 7'b0110111}, 1'b1, 14, 32'h1234_5000);
        add_step(enc_i(12'h678, 14, 3'b000, 14), 1'b1, 14, 32'h1234_5678);
        // Store then load with each load used at once
        add_step(enc_sw(12'd8, 14, 0), 1'b0, 0, 32'h0);
        add_step(enc_lw(12'd8, 0, 15), 1'b1, 15, 32'h1234_5678);
        add_step(enc_r(7'h00, 1, 15, 3'b000, 16), 1'b1, 16, 32'h1234_567D);
        add_step(enc_lw(12'd8, 0, 17), 1'b1, 17, 32'h1234_5678);
        add_step(enc_sw(12'd12, 17, 0), 1'b0, 0, 32'h0);
        add_step(enc_lw(12'd4, 7, 18), 1'b1, 18, 32'h1234_5678);
        // x0 stays zero and BEQ retires with no write
        add_step(enc_i(12'd7, 1, 3'b000, 0), 1'b0, 0, 32'h0);
        add_step(enc_i(12'd9, 0, 3'b000, 19), 1'b1, 19, 32'h0000_0009);
        add_step(32'h0000_0063, 1'b0, 0, 32'h0);
        add_step(enc_r(7'h00, 0, 19, 3'b000, 20), 1'b1, 20, 32'h0000_0009);
        add_step(enc_r(7'h00, 12, 16, 3'b111, 21), 1'b1, 21, 32'h1234_5600);
    endtask

    task automatic check_retire(input rv_pkg::retire_t got, input rv_pkg::retire_t exp,
                                input int idx);
        if (got.we !== exp.we)
        begin
            $display("Fail at %0d ns: retire %0d we is %0b, expected %0b",
                     $time, idx, got.we, exp.we);
            retire_errors++;
        end
        // rd and data only matter when a register is written
        if (exp.we && (got.rd !== exp.rd))
        begin
            $display("Fail at %0d ns: retire %0d rd is %0d, expected %0d",
                     $time, idx, got.rd, exp.rd);
            retire_errors++;
        end
        if (exp.we && (got.data !== exp.data))
        begin
            $display("Fail at %0d ns: retire %0d data is %h, expected %h",
                     $time, idx, got.data, exp.data);
            retire_errors++;
        end
    endtask

    task automatic check_fetch_addr(input logic [rv_pkg::XLEN-1:0] got,
                                    input logic [rv_pkg::XLEN-1:0] lo,
                                    input logic [rv_pkg::XLEN-1:0] hi);
        if ((got !== lo) && (got !== hi))
        begin
            $display("Fail at %0d ns: fetch address %h, expected %h or %h", $time, got, lo, hi);
            fetch_errors++;
        end
    endtask

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Instruction memory answers in the same cycle with NOPs past the table
    always_comb
    begin
        i_imem_instr = rv_pkg::NOP_INSTR;
        if (o_imem_addr[rv_pkg::XLEN-1:2] < prog_instr.size())
        begin
            i_imem_instr = prog_instr[o_imem_addr[rv_pkg::XLEN-1:2]];
        end
    end

    always @(negedge clk)
    begin
        if (checking)
        begin
            check_fetch_addr(o_imem_addr, prev_pc, prev_pc + 32'd4);
            prev_pc = o_imem_addr;
            if (o_retire.valid)
            begin
                if (n_retired < prog_exp.size())
                begin
                    check_retire(o_retire, prog_exp[n_retired], n_retired);
                end
                n_retired++;
            end
        end
    end

    initial
    begin
        i_rst_n       = 1'b0;
        checking      = 1'b0;
        n_retired     = 0;
        retire_errors = 0;
        fetch_errors  = 0;
        prev_pc       = '0;
        load_program();
        repeat (4) @(posedge clk);
        i_rst_n <= 1'b1;
        @(negedge clk);
        check_fetch_addr(o_imem_addr, '0, '0);
        if (o_retire.valid)
        begin
            $display("Fail at %0d ns: retire valid right after reset", $time);
            retire_errors++;
        end
        prev_pc  = o_imem_addr;
        checking = 1'b1;
        wait (n_retired >= prog_exp.size());
        repeat (2) @(posedge clk);
        $display("Errors: %0d retire, %0d fetch, %0d assertion",
                 retire_errors, fetch_errors, dut.u_props.assert_errors);
        if ((retire_errors + fetch_errors + dut.u_props.assert_errors) == 0)
        begin
            $display("All checks passed");
        end
        else
        begin
            $display("Checks failed");
        end
        $finish;
    end

    initial
    begin : watchdog
        int loads;
        loads = 0;
        wait (i_rst_n === 1'b1);
        foreach (prog_instr[i])
        begin
            if (prog_instr[i][6:0] == 7'b0000011)
            begin
                loads++;
            end
        end
        repeat (prog_instr.size() + 2 * loads + 20) @(posedge clk);
        $display("Timeout: retire stream stalled with %0d of %0d records retired",
                 n_retired, prog_exp.size());
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== compile.f ====
hdl/rv_pkg.sv
hdl/pipe_reg.sv
hdl/reg_file.sv
hdl/decode_stage.sv
hdl/hazard_unit.sv
hdl/execute_stage.sv
hdl/data_mem.sv
hdl/rv_core_top.sv
tb/rv_core_properties.sv
tb/rv_core_tb.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - hdl/rv_pkg.sv
  - hdl/pipe_reg.sv
  - hdl/reg_file.sv
  - hdl/decode_stage.sv
  - hdl/hazard_unit.sv
  - hdl/execute_stage.sv
  - hdl/data_mem.sv
  - hdl/rv_core_top.sv
  - target: simulation
    files:
      - tb/rv_core_properties.sv
      - tb/rv_core_tb.sv
